// ==== Bender.yml ====
package:
  name: dcache

sources:
  # Shared geometry and types
  - files:
      - source/dcachePkg.sv
  # Internal buses
  - files:
      - source/cacheIf.sv
  # Design
  - files:
      - source/tagStore.sv
      - source/lineStore.sv
      - source/wayPick.sv
      - source/cacheCtrl.sv
      - source/dcacheTop.sv
  # Testbench
  - target: test
    files:
      - tb/dcacheTb.sv

// ==== all.f ====
source/dcachePkg.sv
source/cacheIf.sv
source/tagStore.sv
source/lineStore.sv
source/wayPick.sv
source/cacheCtrl.sv
source/dcacheTop.sv
tb/dcacheTb.sv

// ==== source/cacheCtrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module cacheCtrl #(
	parameter int MemCredits = 2
) (
	input logic clk,
	input logic rst,
	input logic cpuReq,
	input logic cpuWrite,
	input dcachePkg::addrT cpuAddr,
	input dcachePkg::wordT cpuWdata,
	output logic cpuReady,
	output logic cpuRvalid,
	output dcachePkg::wordT cpuRdata,
	output logic memReqValid,
	output logic memReqWrite,
	output dcachePkg::addrT memReqAddr,
	output dcachePkg::wordT memReqData,
	input logic memCredit,
	input logic memRspValid,
	input dcachePkg::wordT memRspData,
	lookupIf.ctrl lookup,
	lineIf.ctrl line
);

	localparam int CntBits = $clog2(MemCredits + 1);

	typedef enum logic [2:0] {Idle, Lookup, Read, Issue, FillWait, Fill, Respond} stateT;

	stateT state;
	logic [CntBits-1:0] credits;
	logic reqWrite;
	dcachePkg::addrT reqAddr;
	dcachePkg::wordT reqWdata;
	dcachePkg::wordT rspData;
	dcachePkg::setT reqSet;
	dcachePkg::tagT reqTag;
	dcachePkg::wayT pickWay;
	logic issue;

	// Address split for the held request
	assign reqSet = reqAddr[dcachePkg::SetBits+1:2];
	assign reqTag = reqAddr[31:dcachePkg::SetBits+2];

	// A request goes out only while at least one credit is left
	assign issue = (state == Issue) && (credits != '0);

	// ========================================================================
	// Request FSM
	// ========================================================================

	// Lookup drives the tag compare, Read sees its result a cycle later
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= Idle;
		end else begin
			case (state)
				Idle: if (cpuReq) state <= Lookup;
				Lookup: state <= Read;
				Read: state <= (!reqWrite && lookup.hit) ? Respond : Issue;
				Issue: if (issue) state <= reqWrite ? Idle : FillWait;
				FillWait: if (memRspValid) state <= Fill;
				default: state <= Idle;
			endcase
		end
	end

	// Request payload is captured when it is accepted
	always_ff @(posedge clk) begin
		if (cpuReq && cpuReady) begin
			reqWrite <= cpuWrite;
			reqAddr <= cpuAddr;
			reqWdata <= cpuWdata;
		end
		if (state == FillWait && memRspValid) rspData <= memRspData;
	end

	// Credits come back and go out independently, possibly in the same cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			credits <= CntBits'(MemCredits);
		end else if (memCredit && !issue) begin
			credits <= credits + 1'b1;
		end else if (!memCredit && issue) begin
			credits <= credits - 1'b1;
		end
	end

	// Store hits keep their way, fills take the LFSR way
	wayPick picker (
		.clk(clk),
		.rst(rst),
		.storeHit(state == Read && reqWrite && lookup.hit),
		.fill(state == FillWait && memRspValid),
		.hitWay(lookup.hitWay),
		.writeWay(pickWay)
	);

	// ========================================================================
	// Outputs
	// ========================================================================

	assign cpuReady = (state == Idle);
	assign cpuRvalid = (state == Respond) || (state == Fill);
	// Misses answer with the memory word, hits with the line store word
	assign cpuRdata = (state == Fill) ? rspData : line.readData;

	assign memReqValid = issue;
	assign memReqWrite = reqWrite;
	assign memReqAddr = reqAddr;
	assign memReqData = reqWdata;

	assign lookup.lookupValid = (state == Lookup);
	assign lookup.lookupSet = reqSet;
	assign lookup.lookupTag = reqTag;
	assign lookup.fillValid = (state == Fill);
	assign lookup.fillSet = reqSet;
	assign lookup.fillTag = reqTag;
	assign lookup.fillWay = pickWay;

	// Only a load that hit needs the line store read
	assign line.readValid = (state == Read) && !reqWrite && lookup.hit;
	assign line.readSet = reqSet;
	assign line.readWay = lookup.hitWay;
	// A store hit updates its line at the same time as the memory write
	assign line.writeValid = (issue && reqWrite && lookup.hit) || (state == Fill);
	assign line.writeSet = reqSet;
	assign line.writeWay = pickWay;
	assign line.writeData = (state == Fill) ? rspData : reqWdata;

endmodule

`default_nettype wire

// ==== source/cacheIf.sv ====
`timescale 1ns/1ps
`default_nettype none

// Tag lookup and tag fill between the controller and the tag store
interface lookupIf;
	logic lookupValid;
	dcachePkg::setT lookupSet;
	dcachePkg::tagT lookupTag;
	// Result, registered one cycle after lookupValid
	logic hit;
	dcachePkg::wayT hitWay;
	logic fillValid;
	dcachePkg::setT fillSet;
	dcachePkg::tagT fillTag;
	dcachePkg::wayT fillWay;

	modport ctrl (
		output lookupValid, lookupSet, lookupTag,
		output fillValid, fillSet, fillTag, fillWay,
		input hit, hitWay
	);

	modport store (
		input lookupValid, lookupSet, lookupTag,
		input fillValid, fillSet, fillTag, fillWay,
		output hit, hitWay
	);
endinterface

// Word read and word write between the controller and the line store
interface lineIf;
	logic readValid;
	dcachePkg::setT readSet;
	dcachePkg::wayT readWay;
	dcachePkg::wordT readData;
	logic writeValid;
	dcachePkg::setT writeSet;
	dcachePkg::wayT writeWay;
	dcachePkg::wordT writeData;

	modport ctrl (
		output readValid, readSet, readWay,
		output writeValid, writeSet, writeWay, writeData,
		input readData
	);

	modport store (
		input readValid, readSet, readWay,
		input writeValid, writeSet, writeWay, writeData,
		output readData
	);
endinterface

`default_nettype wire

// ==== source/dcachePkg.sv ====
`default_nettype none

// ============================================================================
// Cache geometry and the shared data types
// ============================================================================

package dcachePkg;

	// Number of ways in each set
	localparam int Ways = 4;

	// Width of the set index, giving 16 sets
	localparam int SetBits = 4;

	// Tag is what remains above the set index and the two byte-offset bits
	localparam int TagBits = 32 - SetBits - 2;

	// Byte address from the load/store unit, always word aligned
	typedef logic [31:0] addrT;

	// One data word, which is also one full cache line
	typedef logic [31:0] wordT;

	// Set index taken from address bits just above the byte offset
	typedef logic [SetBits-1:0] setT;

	// Tag kept per way to identify the cached address
	typedef logic [TagBits-1:0] tagT;

	// Way number within a set
	typedef logic [1:0] wayT;

endpackage

`default_nettype wire

// ==== source/dcacheTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcacheTop #(
	parameter int MemCredits = 2
) (
	input logic clk,
	input logic rst,
	// Load/store unit side
	input logic cpuReq,
	input logic cpuWrite,
	input dcachePkg::addrT cpuAddr,
	input dcachePkg::wordT cpuWdata,
	output logic cpuReady,
	output logic cpuRvalid,
	output dcachePkg::wordT cpuRdata,
	// Memory side, credit based
	output logic memReqValid,
	output logic memReqWrite,
	output dcachePkg::addrT memReqAddr,
	output dcachePkg::wordT memReqData,
	input logic memCredit,
	input logic memRspValid,
	input dcachePkg::wordT memRspData
);

	// Internal buses between the controller and the two stores
	lookupIf lookupBus ();
	lineIf lineBus ();

	// Tags and valid bits
	tagStore tagArray (
		.clk(clk),
		.rst(rst),
		.lookup(lookupBus.store)
	);

	// Data words, side by side with the tags
	lineStore lineArray (
		.clk(clk),
		.line(lineBus.store)
	);

	// Request sequencing, credit tracking and the response mux
	cacheCtrl #(
		.MemCredits(MemCredits)
	) controller (
		.clk(clk),
		.rst(rst),
		.cpuReq(cpuReq),
		.cpuWrite(cpuWrite),
		.cpuAddr(cpuAddr),
		.cpuWdata(cpuWdata),
		.cpuReady(cpuReady),
		.cpuRvalid(cpuRvalid),
		.cpuRdata(cpuRdata),
		.memReqValid(memReqValid),
		.memReqWrite(memReqWrite),
		.memReqAddr(memReqAddr),
		.memReqData(memReqData),
		.memCredit(memCredit),
		.memRspValid(memRspValid),
		.memRspData(memRspData),
		.lookup(lookupBus.ctrl),
		.line(lineBus.ctrl)
	);

endmodule

`default_nettype wire

// ==== source/lineStore.sv ====
`timescale 1ns/1ps
`default_nettype none

module lineStore (
	input logic clk,
	lineIf.store line
);

	localparam int Sets = 1 << dcachePkg::SetBits;

	// Data word for every way of every set
	// Each line is a single word, so no word select is needed
	dcachePkg::wordT words [Sets][dcachePkg::Ways];

	// ========================================================================
	// Write port
	// ========================================================================

	// Used by a store that hits and by a fill after a load miss
	// The controller picks the way through wayPick in both cases
	always_ff @(posedge clk) begin
		if (line.writeValid) begin
			words[line.writeSet][line.writeWay] <= line.writeData;
		end
	end

	// ========================================================================
	// Read port
	// ========================================================================

	// The read is registered, so data shows up the cycle after readValid
	// A write to the same location in the same cycle is not seen here,
	// the old word comes out
	always_ff @(posedge clk) begin
		if (line.readValid) begin
			line.readData <= words[line.readSet][line.readWay];
		end
	end

endmodule

`default_nettype wire

// ==== source/tagStore.sv ====
`timescale 1ns/1ps
`default_nettype none

module tagStore (
	input logic clk,
	input logic rst,
	lookupIf.store lookup
);

	localparam int Sets = 1 << dcachePkg::SetBits;

	// One valid bit per way, grouped by set
	logic [dcachePkg::Ways-1:0] validBits [Sets];

	// Tag of every way in every set
	dcachePkg::tagT tags [Sets][dcachePkg::Ways];

	// Compare result before it is registered
	logic matchAny;
	dcachePkg::wayT matchWay;

	// ========================================================================
	// Tag compare
	// ========================================================================

	// All four ways of the set are checked in parallel
	// The lowest matching way wins, although a fill never creates two matches
	always_comb begin
		matchAny = 1'b0;
		matchWay = '0;
		for (int w = dcachePkg::Ways - 1; w >= 0; w--) begin
			if (validBits[lookup.lookupSet][w] && tags[lookup.lookupSet][w] == lookup.lookupTag) begin
				matchAny = 1'b1;
				matchWay = dcachePkg::wayT'(w);
			end
		end
	end

	// Hit and hit way hold until the controller starts the next lookup
	always_ff @(posedge clk) begin
		if (rst) begin
			lookup.hit <= 1'b0;
		end else if (lookup.lookupValid) begin
			lookup.hit <= matchAny;
		end
	end

	always_ff @(posedge clk) begin
		if (lookup.lookupValid) begin
			lookup.hitWay <= matchWay;
		end
	end

	// ========================================================================
	// Fill
	// ========================================================================

	// Reset empties the cache by clearing every valid bit
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int s = 0; s < Sets; s++) begin
				validBits[s] <= '0;
			end
		end else if (lookup.fillValid) begin
			validBits[lookup.fillSet][lookup.fillWay] <= 1'b1;
		end
	end

	// The tag lands in the same cycle as its valid bit
	always_ff @(posedge clk) begin
		if (lookup.fillValid) begin
			tags[lookup.fillSet][lookup.fillWay] <= lookup.fillTag;
		end
	end

endmodule

`default_nettype wire

// ==== source/wayPick.sv ====
`timescale 1ns/1ps
`default_nettype none

module wayPick (
	input logic clk,
	input logic rst,
	input logic storeHit,
	input logic fill,
	input dcachePkg::wayT hitWay,
	output dcachePkg::wayT writeWay
);

	// Two-bit Galois LFSR for x^2 + x + 1, period three
	// It never reaches zero, so way 0 only comes from a store hit or reset
	dcachePkg::wayT lfsr;

	always_ff @(posedge clk) begin
		if (rst) begin
			lfsr <= 2'b01;
		end else begin
			lfsr <= (lfsr >> 1) ^ (lfsr[0] ? 2'b11 : 2'b00);
		end
	end

	// The way chosen here is used by the next tag or line write
	// A store hit keeps the way it hit, a fill takes the current LFSR value
	always_ff @(posedge clk) begin
		if (rst) begin
			writeWay <= '0;
		end else if (storeHit) begin
			writeWay <= hitWay;
		end else if (fill) begin
			writeWay <= lfsr;
		end
	end

endmodule

`default_nettype wire

// ==== tb/dcacheTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcacheTb;

	localparam int MemCredits = 2;
	// Sum of the worst-case lengths of the six tests
	localparam int WatchdogCycles = 4000;

	logic clk;
	logic rst;
	logic cpuReq;
	logic cpuWrite;
	logic [31:0] cpuAddr;
	logic [31:0] cpuWdata;
	logic cpuReady;
	logic cpuRvalid;
	logic [31:0] cpuRdata;
	logic memReqValid;
	logic memReqWrite;
	logic [31:0] memReqAddr;
	logic [31:0] memReqData;
	logic memCredit;
	logic memRspValid;
	logic [31:0] memRspData;

	// The memory model keeps the pending requests in issue order and every word written so far
	logic holdCredits;
	int pendDelay [$];
	logic pendWrite [$];
	logic [31:0] pendData [$];
	logic [31:0] writtenAddr [$];
	logic [31:0] writtenData [$];
	logic [31:0] lastWriteAddr;
	logic [31:0] lastWriteData;
	int readReqs;
	int writeReqs;
	int peakOutstanding;
	logic [31:0] lfsrState;

	int errors;
	int testsRun;
	int testsFailed;

	dcacheTop #(
		.MemCredits(MemCredits)
	) DUT (
		.clk(clk),
		.rst(rst),
		.cpuReq(cpuReq),
		.cpuWrite(cpuWrite),
		.cpuAddr(cpuAddr),
		.cpuWdata(cpuWdata),
		.cpuReady(cpuReady),
		.cpuRvalid(cpuRvalid),
		.cpuRdata(cpuRdata),
		.memReqValid(memReqValid),
		.memReqWrite(memReqWrite),
		.memReqAddr(memReqAddr),
		.memReqData(memReqData),
		.memCredit(memCredit),
		.memRspValid(memRspValid),
		.memRspData(memRspData)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ========================================================================
	// Helpers
	// ========================================================================

	// Galois LFSR with taps 32, 22, 2 and 1
	function automatic logic [31:0] nextLfsr(input logic [31:0] state);
		return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
	endfunction

	function automatic logic takeBit();
		logic bitOut;
		bitOut = lfsrState[0];
		lfsrState = nextLfsr(lfsrState);
		return bitOut;
	endfunction

	// Unwritten memory answers with a word built from the whole address
	function automatic logic [31:0] patternWord(input logic [31:0] addr);
		return {addr[15:0], addr[31:16]} ^ 32'h5A3C_96E1;
	endfunction

	// The latest write to an address wins over the pattern
	function automatic logic [31:0] memoryWord(input logic [31:0] addr);
		logic [31:0] word;
		word = patternWord(addr);
		foreach (writtenAddr[i]) begin
			if (writtenAddr[i] == addr) word = writtenData[i];
		end
		return word;
	endfunction

	task automatic mismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
		errors++;
		$display("[ERROR] %s: got %h, expected %h at %0t", name, got, exp, $time);
	endtask

	task automatic problem(input string what);
		errors++;
		$display("Failure at %0t: %s", $time, what);
	endtask

	task automatic endTest(input string name, input int startErrors);
		testsRun++;
		if (errors == startErrors) begin
			$display("%s: passed", name);
		end else begin
			testsFailed++;
			$display("%s: failed with %0d errors", name, errors - startErrors);
		end
	endtask

	// ========================================================================
	// Memory model
	// ========================================================================

	// Credits return in issue order and at most once per cycle, 1 to 4 cycles late
	// A read's data rides on the same cycle as its credit
	always @(negedge clk) begin
		int delay;
		memCredit = 1'b0;
		memRspValid = 1'b0;
		for (int i = 0; i < pendDelay.size(); i++) begin
			if (pendDelay[i] > 0) pendDelay[i]--;
		end
		if (!holdCredits && pendDelay.size() > 0 && pendDelay[0] == 0) begin
			memCredit = 1'b1;
			if (!pendWrite[0]) begin
				memRspValid = 1'b1;
				memRspData = pendData[0];
			end
			void'(pendDelay.pop_front());
			void'(pendWrite.pop_front());
			void'(pendData.pop_front());
		end
		if (memReqValid) begin
			delay = 1;
			if (takeBit()) delay += 2;
			if (takeBit()) delay += 1;
			pendDelay.push_back(delay);
			pendWrite.push_back(memReqWrite);
			if (memReqWrite) begin
				writeReqs++;
				writtenAddr.push_back(memReqAddr);
				writtenData.push_back(memReqData);
				lastWriteAddr = memReqAddr;
				lastWriteData = memReqData;
				pendData.push_back(memReqData);
			end else begin
				readReqs++;
				pendData.push_back(memoryWord(memReqAddr));
			end
			if (pendDelay.size() > peakOutstanding) peakOutstanding = pendDelay.size();
		end
	end

	// ========================================================================
	// CPU side
	// ========================================================================

	// Called at a falling edge and returns at the falling edge after acceptance
	task automatic sendRequest(input logic write, input logic [31:0] addr,
		input logic [31:0] data);
		while (!cpuReady) @(negedge clk);
		cpuReq = 1'b1;
		cpuWrite = write;
		cpuAddr = addr;
		cpuWdata = data;
		@(negedge clk);
		cpuReq = 1'b0;
	endtask

	task automatic waitReady(output int cycles);
		cycles = 0;
		while (!cpuReady) begin
			@(negedge clk);
			cycles++;
		end
	endtask

	// Cycles counts falling edges from acceptance to cpuRvalid
	task automatic loadWord(input logic [31:0] addr, output logic [31:0] data,
		output int cycles, output int reads);
		int readsBefore;
		readsBefore = readReqs;
		sendRequest(1'b0, addr, '0);
		cycles = 0;
		while (!cpuRvalid) begin
			@(negedge clk);
			cycles++;
		end
		data = cpuRdata;
		reads = readReqs - readsBefore;
	endtask

	task automatic storeWord(input logic [31:0] addr, input logic [31:0] data,
		output int cycles);
		sendRequest(1'b1, addr, data);
		waitReady(cycles);
	endtask

	// Lets all credits flow back so the next test starts with a full count
	task automatic settle();
		while (pendDelay.size() != 0) @(negedge clk);
		repeat (2) @(negedge clk);
		peakOutstanding = 0;
	endtask

	// ========================================================================
	// Tests
	// ========================================================================

	task automatic resetStateTest();
		int startErrors;
		int writesBefore;
		int cycles;
		startErrors = errors;
		if (cpuReady !== 1'b1) mismatch("cpuReady", cpuReady, 1);
		if (memReqValid !== 1'b0) mismatch("memReqValid", memReqValid, 0);
		if (cpuRvalid !== 1'b0) mismatch("cpuRvalid", cpuRvalid, 0);
		// Both reset credits are spent and none come back
		holdCredits = 1'b1;
		writesBefore = writeReqs;
		storeWord(32'h0000_4000, 32'h1111_0001, cycles);
		if (cycles != 3) mismatch("cpuReady delay", cycles, 3);
		storeWord(32'h0000_4004, 32'h1111_0002, cycles);
		if (cycles != 3) mismatch("cpuReady delay", cycles, 3);
		sendRequest(1'b1, 32'h0000_4008, 32'h1111_0003);
		repeat (8) @(negedge clk);
		if (writeReqs - writesBefore != 2) mismatch("memory writes", writeReqs - writesBefore, 2);
		if (cpuReady) problem("a third store completed with no credit left");
		holdCredits = 1'b0;
		waitReady(cycles);
		if (writeReqs - writesBefore != 3) mismatch("memory writes", writeReqs - writesBefore, 3);
		settle();
		endTest("reset state", startErrors);
	endtask

	task automatic missThenHitTest();
		int startErrors;
		int cycles;
		int reads;
		logic [31:0] addr;
		logic [31:0] data;
		startErrors = errors;
		addr = 32'h0000_1040;
		loadWord(addr, data, cycles, reads);
		if (reads != 1) mismatch("memory reads", reads, 1);
		if (data !== patternWord(addr)) mismatch("cpuRdata", data, patternWord(addr));
		loadWord(addr, data, cycles, reads);
		if (reads != 0) mismatch("memory reads", reads, 0);
		if (data !== patternWord(addr)) mismatch("cpuRdata", data, patternWord(addr));
		if (cycles != 2) mismatch("cpuRvalid delay", cycles, 2);
		settle();
		endTest("load miss then hit", startErrors);
	endtask

	task automatic storeHitTest();
		int startErrors;
		int cycles;
		int reads;
		int writesBefore;
		logic [31:0] addr;
		logic [31:0] data;
		startErrors = errors;
		addr = 32'h0000_2088;
		// The load brings the line in, so the store below hits
		loadWord(addr, data, cycles, reads);
		writesBefore = writeReqs;
		storeWord(addr, 32'hCAFE_3003, cycles);
		if (writeReqs - writesBefore != 1) mismatch("memory writes", writeReqs - writesBefore, 1);
		if (lastWriteAddr !== addr) mismatch("memReqAddr", lastWriteAddr, addr);
		if (lastWriteData !== 32'hCAFE_3003) mismatch("memReqData", lastWriteData, 32'hCAFE_3003);
		loadWord(addr, data, cycles, reads);
		if (reads != 0) mismatch("memory reads", reads, 0);
		if (data !== 32'hCAFE_3003) mismatch("cpuRdata", data, 32'hCAFE_3003);
		settle();
		endTest("store write-through with hit update", startErrors);
	endtask

	task automatic storeMissTest();
		int startErrors;
		int cycles;
		int reads;
		int writesBefore;
		logic [31:0] addr;
		logic [31:0] data;
		startErrors = errors;
		addr = 32'h0000_30C4;
		writesBefore = writeReqs;
		storeWord(addr, 32'hBEEF_4004, cycles);
		if (writeReqs - writesBefore != 1) mismatch("memory writes", writeReqs - writesBefore, 1);
		if (lastWriteAddr !== addr) mismatch("memReqAddr", lastWriteAddr, addr);
		if (lastWriteData !== 32'hBEEF_4004) mismatch("memReqData", lastWriteData, 32'hBEEF_4004);
		// No allocate, so this load has to go to memory
		loadWord(addr, data, cycles, reads);
		if (reads != 1) mismatch("memory reads", reads, 1);
		if (data !== 32'hBEEF_4004) mismatch("cpuRdata", data, 32'hBEEF_4004);
		settle();
		endTest("store miss without allocate", startErrors);
	endtask

	task automatic backPressureTest();
		int startErrors;
		int cycles;
		int reads;
		int readsBefore;
		int early;
		logic [31:0] data;
		startErrors = errors;
		holdCredits = 1'b1;
		storeWord(32'h0000_5100, 32'h5555_0001, cycles);
		storeWord(32'h0000_5104, 32'h5555_0002, cycles);
		readsBefore = readReqs;
		sendRequest(1'b0, 32'h0000_5200, '0);
		early = 0;
		repeat (8) begin
			@(negedge clk);
			if (cpuReady || cpuRvalid) early++;
		end
		if (early != 0) problem("the load finished while no credit was free");
		if (readReqs != readsBefore) problem("a memory read went out with no credit left");
		if (peakOutstanding > MemCredits) mismatch("outstanding requests", peakOutstanding, MemCredits);
		holdCredits = 1'b0;
		while (!cpuRvalid) @(negedge clk);
		if (cpuRdata !== patternWord(32'h0000_5200)) begin
			mismatch("cpuRdata", cpuRdata, patternWord(32'h0000_5200));
		end
		loadWord(32'h0000_5100, data, cycles, reads);
		if (data !== 32'h5555_0001) mismatch("cpuRdata", data, 32'h5555_0001);
		loadWord(32'h0000_5104, data, cycles, reads);
		if (data !== 32'h5555_0002) mismatch("cpuRdata", data, 32'h5555_0002);
		if (peakOutstanding > MemCredits) mismatch("outstanding requests", peakOutstanding, MemCredits);
		settle();
		endTest("credit back-pressure", startErrors);
	endtask

	// Six tags in set 5 compete for four ways
	task automatic replacementTest();
		int startErrors;
		int cycles;
		int reads;
		int hits;
		logic [31:0] addr;
		logic [31:0] data;
		startErrors = errors;
		hits = 0;
		for (int round = 0; round < 2; round++) begin
			for (int k = 1; k <= 6; k++) begin
				addr = 32'h0006_0014 + k * 32'h100;
				loadWord(addr, data, cycles, reads);
				if (data !== patternWord(addr)) mismatch("cpuRdata", data, patternWord(addr));
				if (round == 0 && reads != 1) mismatch("memory reads", reads, 1);
				if (round == 1 && reads == 0) hits++;
			end
		end
		if (hits > 4) mismatch("second-round hits", hits, 4);
		settle();
		endTest("replacement", startErrors);
	endtask

	// ========================================================================
	// Sequence and watchdog
	// ========================================================================

	initial begin
		rst = 1'b1;
		cpuReq = 1'b0;
		cpuWrite = 1'b0;
		cpuAddr = '0;
		cpuWdata = '0;
		memCredit = 1'b0;
		memRspValid = 1'b0;
		memRspData = '0;
		holdCredits = 1'b0;
		lastWriteAddr = '0;
		lastWriteData = '0;
		readReqs = 0;
		writeReqs = 0;
		peakOutstanding = 0;
		lfsrState = 32'h8054;
		errors = 0;
		testsRun = 0;
		testsFailed = 0;
		// Reset spans eight rising edges and drops at the next falling edge
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		resetStateTest();
		missThenHitTest();
		storeHitTest();
		storeMissTest();
		backPressureTest();
		replacementTest();
		$display("%0d tests run, %0d failed, %0d errors", testsRun, testsFailed, errors);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

	initial begin
		repeat (WatchdogCycles) @(posedge clk);
		$display("Timeout: the tests did not finish within %0d cycles", WatchdogCycles);
		$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire
